// File: source/dbus_consts.svh
`ifndef DBUS_CONSTS_SVH
`define DBUS_CONSTS_SVH

//////////////////////////////
// Data-port bus widths
//////////////////////////////
`define DBUS_ADDR_W 32
`define DBUS_DATA_W 32
`define DBUS_STRB_W 4
`define DBUS_CTRL_W 2

// Access codes on the control lines
`define CTRL_NONE  2'd0
`define CTRL_READ  2'd1
`define CTRL_WRITE 2'd2

//////////////////////////////
// Address map
//////////////////////////////
`define PERIPH_BASE_ADDR 32'h1000_0000
`define CONSOLE_ADDR     32'h0001_0150

`endif

// File: source/dbus_pkg.sv
`default_nettype none
`include "dbus_consts.svh"

package dbus_pkg;

    // Byte address from the core
    typedef logic [`DBUS_ADDR_W-1:0] addr_t;

    // One data word, either direction
    typedef logic [`DBUS_DATA_W-1:0] data_t;

    // Byte enables, one per byte lane
    typedef logic [`DBUS_STRB_W-1:0] strb_t;

    // None, read or write
    typedef logic [`DBUS_CTRL_W-1:0] ctrl_t;

endpackage

`default_nettype wire

// File: source/peri_pkg.sv
`default_nettype none

package peri_pkg;

    // Core-side sequencer around one peripheral access
    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_ISSUE,
        SEQ_WAIT,
        SEQ_RESPOND
    } peri_seq_state_t;

    // External channel sequence of the bus master
    typedef enum logic [2:0] {
        BUS_IDLE,
        BUS_WR_REQ,
        BUS_WR_WAIT,
        BUS_RD_REQ,
        BUS_RD_DATA,
        BUS_DONE
    } peri_bus_state_t;

endpackage

`default_nettype wire

// File: source/peri_req_if.sv
`timescale 1ns/10ps
`default_nettype none

interface peri_req_if
    import dbus_pkg::*;
;
    // Request, held stable while start pulses
    logic  start;
    logic  write;
    addr_t addr;
    data_t wdata;
    strb_t wstrb;

    // Completion, rdata valid with done
    logic  done;
    data_t rdata;

    modport requester (
        output start, write, addr, wdata, wstrb,
        input  done, rdata
    );

    modport responder (
        input  start, write, addr, wdata, wstrb,
        output done, rdata
    );

endinterface

`default_nettype wire

// File: source/access_decoder.sv
`timescale 1ns/10ps
`default_nettype none
`include "dbus_consts.svh"

module access_decoder
    import dbus_pkg::*;
(
    input  wire        CLK,
    input  wire        reset,
    input  wire ctrl_t proc_ctrl,
    input  wire addr_t proc_addr,
    input  wire data_t proc_wdata,
    input  wire        cache_ready,
    input  wire        fetch_ready,
    input  wire        seq_busy,
    output ctrl_t      cache_ctrl,
    output logic       peri_hit,
    output logic       console_wr_en,
    output data_t      console_wr_data
);

    logic is_peri;
    logic is_console;
    logic console_wr;

    //////////////////////////////
    // Address classification
    //////////////////////////////
    assign is_peri    = (proc_addr >= `PERIPH_BASE_ADDR);
    assign is_console = (proc_addr == `CONSOLE_ADDR);

    // Cache only sees cacheable accesses
    assign cache_ctrl = (is_peri || is_console) ? `CTRL_NONE : proc_ctrl;

    assign peri_hit = is_peri && (proc_ctrl != `CTRL_NONE) && cache_ready && fetch_ready
                      && !seq_busy;

    assign console_wr = is_console && (proc_ctrl == `CTRL_WRITE) && cache_ready
                        && fetch_ready;

    //////////////////////////////
    // Console FIFO port
    //////////////////////////////
    always_ff @(posedge CLK)
    begin
        if (reset)
        begin
            console_wr_en <= 1'b0;
        end
        else
        begin
            console_wr_en <= console_wr;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (console_wr)
        begin
            console_wr_data <= proc_wdata;
        end
    end

    // One pulse per console write
    a_console_single: assert property (
        @(posedge CLK) disable iff (reset) console_wr_en |=> !console_wr_en
    );

endmodule

`default_nettype wire

// File: source/peri_sequencer.sv
`timescale 1ns/10ps
`default_nettype none
`include "dbus_consts.svh"

module peri_sequencer
    import dbus_pkg::*;
    import peri_pkg::*;
(
    input  wire        CLK,
    input  wire        reset,
    input  wire        peri_hit,
    input  wire ctrl_t proc_ctrl,
    input  wire addr_t proc_addr,
    input  wire data_t proc_wdata,
    input  wire strb_t proc_strb,
    input  wire        cache_ready,
    input  wire data_t cache_rdata,
    peri_req_if.requester req,
    output logic       seq_busy,
    output logic       fetch_hold,
    output logic       proc_data_ready,
    output data_t      proc_rdata
);

    peri_seq_state_t state;
    peri_seq_state_t state_nxt;

    logic  write_q;
    addr_t addr_q;
    data_t wdata_q;
    strb_t strb_q;
    data_t rdata_q;

    //////////////////////////////
    // FSM
    //////////////////////////////
    always_comb
    begin
        state_nxt = state;
        case (state)
            SEQ_IDLE:    if (peri_hit) state_nxt = SEQ_ISSUE;
            SEQ_ISSUE:   state_nxt = SEQ_WAIT;
            SEQ_WAIT:    if (req.done) state_nxt = SEQ_RESPOND;
            SEQ_RESPOND: state_nxt = SEQ_IDLE;
            default:     state_nxt = SEQ_IDLE;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (reset)
        begin
            state <= SEQ_IDLE;
        end
        else
        begin
            state <= state_nxt;
        end
    end

    // Request captured at acceptance, response at done
    always_ff @(posedge CLK)
    begin
        if (state == SEQ_IDLE && peri_hit)
        begin
            write_q <= (proc_ctrl == `CTRL_WRITE);
            addr_q  <= proc_addr;
            wdata_q <= proc_wdata;
            strb_q  <= proc_strb;
        end
        if (state == SEQ_WAIT && req.done)
        begin
            rdata_q <= write_q ? '0 : req.rdata;
        end
    end

    assign req.start = (state == SEQ_ISSUE);
    assign req.write = write_q;
    assign req.addr  = addr_q;
    assign req.wdata = wdata_q;
    assign req.wstrb = strb_q;

    //////////////////////////////
    // Core side
    //////////////////////////////
    assign seq_busy   = (state != SEQ_IDLE);
    assign fetch_hold = (state == SEQ_ISSUE) || (state == SEQ_WAIT);

    always_comb
    begin
        proc_data_ready = (state == SEQ_IDLE) ? cache_ready : 1'b0;
        proc_rdata      = cache_rdata;
        if (state == SEQ_RESPOND)
        begin
            proc_data_ready = 1'b1;
            proc_rdata      = rdata_q;
        end
    end

    // Completion only arrives while waiting for it
    a_done_in_wait: assert property (
        @(posedge CLK) disable iff (reset) req.done |-> (state == SEQ_WAIT)
    );

endmodule

`default_nettype wire

// File: source/peri_bus_master.sv
`timescale 1ns/10ps
`default_nettype none

module peri_bus_master
    import dbus_pkg::*;
    import peri_pkg::*;
(
    input  wire        CLK,
    input  wire        reset,
    peri_req_if.responder req,
    output addr_t      rd_addr,
    output logic       rd_addr_valid,
    input  wire        rd_addr_ready,
    output addr_t      wr_addr,
    output logic       wr_valid,
    input  wire        wr_ready,
    output data_t      wr_data,
    output strb_t      wr_strb,
    input  wire data_t rd_data,
    input  wire        rd_data_valid,
    output logic       rd_data_ready,
    input  wire        trans_complete
);

    peri_bus_state_t state;
    peri_bus_state_t state_nxt;

    addr_t addr_q;
    data_t wdata_q;
    strb_t wstrb_q;
    data_t rdata_q;

    //////////////////////////////
    // Channel sequence
    //////////////////////////////
    always_comb
    begin
        state_nxt = state;
        case (state)
            BUS_IDLE:
                if (req.start) state_nxt = req.write ? BUS_WR_REQ : BUS_RD_REQ;
            BUS_WR_REQ:
                if (wr_ready) state_nxt = trans_complete ? BUS_DONE : BUS_WR_WAIT;
            BUS_WR_WAIT:
                if (trans_complete) state_nxt = BUS_DONE;
            BUS_RD_REQ:
                if (rd_addr_ready) state_nxt = BUS_RD_DATA;
            BUS_RD_DATA:
                if (rd_data_valid) state_nxt = BUS_DONE;
            BUS_DONE:
                state_nxt = BUS_IDLE;
            default:
                state_nxt = BUS_IDLE;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (reset)
        begin
            state <= BUS_IDLE;
        end
        else
        begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == BUS_IDLE && req.start)
        begin
            addr_q  <= req.addr;
            wdata_q <= req.wdata;
            wstrb_q <= req.wstrb;
        end
        // Read data taken in the valid cycle
        if (state == BUS_RD_DATA && rd_data_valid)
        begin
            rdata_q <= rd_data;
        end
    end

    assign wr_valid      = (state == BUS_WR_REQ);
    assign rd_addr_valid = (state == BUS_RD_REQ);
    assign rd_data_ready = (state == BUS_RD_DATA);

    assign wr_addr = addr_q;
    assign rd_addr = addr_q;
    assign wr_data = wdata_q;
    assign wr_strb = wstrb_q;

    assign req.done  = (state == BUS_DONE);
    assign req.rdata = rdata_q;

    // New request only while the channels are idle
    a_start_when_idle: assert property (
        @(posedge CLK) disable iff (reset) req.start |-> (state == BUS_IDLE)
    );

endmodule

`default_nettype wire

// File: source/dbus_router.sv
`timescale 1ns/10ps
`default_nettype none

module dbus_router
    import dbus_pkg::*;
(
    input  wire        CLK,
    input  wire        reset,
    // Core data port
    input  wire ctrl_t proc_ctrl,
    input  wire addr_t proc_addr,
    input  wire data_t proc_wdata,
    input  wire strb_t proc_strb,
    output logic       proc_data_ready,
    output data_t      proc_rdata,
    output logic       fetch_hold,
    // Caches
    input  wire        cache_ready,
    input  wire        fetch_ready,
    input  wire data_t cache_rdata,
    output ctrl_t      cache_ctrl,
    // Console FIFO
    output logic       console_wr_en,
    output data_t      console_wr_data,
    // Peripheral channels
    output addr_t      rd_addr,
    output logic       rd_addr_valid,
    input  wire        rd_addr_ready,
    output addr_t      wr_addr,
    output logic       wr_valid,
    input  wire        wr_ready,
    output data_t      wr_data,
    output strb_t      wr_strb,
    input  wire data_t rd_data,
    input  wire        rd_data_valid,
    output logic       rd_data_ready,
    input  wire        trans_complete
);

    logic peri_hit;
    logic seq_busy;

    peri_req_if req_if ();

    access_decoder u_decoder (
        .CLK             (CLK),
        .reset           (reset),
        .proc_ctrl       (proc_ctrl),
        .proc_addr       (proc_addr),
        .proc_wdata      (proc_wdata),
        .cache_ready     (cache_ready),
        .fetch_ready     (fetch_ready),
        .seq_busy        (seq_busy),
        .cache_ctrl      (cache_ctrl),
        .peri_hit        (peri_hit),
        .console_wr_en   (console_wr_en),
        .console_wr_data (console_wr_data)
    );

    peri_sequencer u_sequencer (
        .CLK             (CLK),
        .reset           (reset),
        .peri_hit        (peri_hit),
        .proc_ctrl       (proc_ctrl),
        .proc_addr       (proc_addr),
        .proc_wdata      (proc_wdata),
        .proc_strb       (proc_strb),
        .cache_ready     (cache_ready),
        .cache_rdata     (cache_rdata),
        .req             (req_if.requester),
        .seq_busy        (seq_busy),
        .fetch_hold      (fetch_hold),
        .proc_data_ready (proc_data_ready),
        .proc_rdata      (proc_rdata)
    );

    peri_bus_master u_bus_master (
        .CLK            (CLK),
        .reset          (reset),
        .req            (req_if.responder),
        .rd_addr        (rd_addr),
        .rd_addr_valid  (rd_addr_valid),
        .rd_addr_ready  (rd_addr_ready),
        .wr_addr        (wr_addr),
        .wr_valid       (wr_valid),
        .wr_ready       (wr_ready),
        .wr_data        (wr_data),
        .wr_strb        (wr_strb),
        .rd_data        (rd_data),
        .rd_data_valid  (rd_data_valid),
        .rd_data_ready  (rd_data_ready),
        .trans_complete (trans_complete)
    );

endmodule

`default_nettype wire

// File: test/dbus_router_checker.sv
`timescale 1ns/10ps
`default_nettype none
`include "dbus_consts.svh"

module dbus_router_checker
    import dbus_pkg::*;
    import peri_pkg::*;
(
    input wire        CLK,
    input wire        reset,
    input wire ctrl_t proc_ctrl,
    input wire addr_t proc_addr,
    input wire data_t proc_wdata,
    input wire strb_t proc_strb,
    input wire        proc_data_ready,
    input wire data_t proc_rdata,
    input wire        fetch_hold,
    input wire        cache_ready,
    input wire        fetch_ready,
    input wire data_t cache_rdata,
    input wire ctrl_t cache_ctrl,
    input wire        console_wr_en,
    input wire data_t console_wr_data,
    input wire addr_t rd_addr,
    input wire        rd_addr_valid,
    input wire        rd_addr_ready,
    input wire addr_t wr_addr,
    input wire        wr_valid,
    input wire        wr_ready,
    input wire data_t wr_data,
    input wire strb_t wr_strb,
    input wire data_t rd_data,
    input wire        rd_data_valid,
    input wire        rd_data_ready,
    input wire        trans_complete
);

    string test_name [5] = '{"reset", "cache_access", "console_write", "peri_write", "peri_read"};
    int    checks [5];
    int    errors [5];
    int    err_count = 0;

    // Reference model of the routing rules
    peri_seq_state_t m_state;
    logic  m_done;
    logic  m_write;
    addr_t m_addr;
    data_t m_wdata;
    strb_t m_strb;
    data_t m_rdata;
    logic  m_wr_hs;
    int    m_wr_cnt;
    int    m_rd_cnt;
    logic  con_exp;
    data_t con_data;
    logic  first_seen;

    task automatic check_val(input int idx, input string what, input logic [31:0] exp,
                             input logic [31:0] act);
        checks[idx]++;
        if (exp !== act)
        begin
            errors[idx]++;
            err_count++;
            $display("FAILED %s %s: expected %0h, actual %0h", test_name[idx], what, exp, act);
        end
    endtask

    task automatic flag_error(input int idx, input string msg);
        errors[idx]++;
        err_count++;
        $display("Error in %s: %s", test_name[idx], msg);
    endtask

    task automatic report();
        int total_checks;
        total_checks = 0;
        for (int i = 0; i < 5; i++)
        begin
            $display("%-14s %6d checks %4d errors  %s", test_name[i], checks[i], errors[i],
                     (errors[i] == 0) ? "ok" : "bad");
            total_checks += checks[i];
        end
        $display("Totals: %0d checks, %0d errors", total_checks, err_count);
    endtask

    //////////////////////////////
    // Compare at mid-cycle
    //////////////////////////////
    always @(negedge CLK)
    begin
        logic is_peri;
        logic is_con;
        logic acc;
        int   pidx;
        is_peri = (proc_addr >= `PERIPH_BASE_ADDR);
        is_con  = (proc_addr == `CONSOLE_ADDR);
        acc     = (proc_ctrl != `CTRL_NONE);
        pidx    = m_write ? 3 : 4;
        if (reset)
        begin
            m_state    = SEQ_IDLE;
            m_done     = 1'b0;
            con_exp    = 1'b0;
            first_seen = 1'b0;
        end
        else
        begin
            if (!first_seen)
            begin
                check_val(0, "fetch_hold", 0, 32'(fetch_hold));
                check_val(0, "console_wr_en", 0, 32'(console_wr_en));
                check_val(0, "wr_valid", 0, 32'(wr_valid));
                check_val(0, "rd_addr_valid", 0, 32'(rd_addr_valid));
                check_val(0, "rd_data_ready", 0, 32'(rd_data_ready));
                first_seen = acc;
            end
            check_val(is_con ? 2 : 1, "cache_ctrl",
                      (is_peri || is_con) ? 32'd0 : 32'(proc_ctrl), 32'(cache_ctrl));
            check_val(2, "console_wr_en", 32'(con_exp), 32'(console_wr_en));
            if (con_exp)
                check_val(2, "console_wr_data", con_data, console_wr_data);
            con_exp  = is_con && (proc_ctrl == `CTRL_WRITE) && cache_ready && fetch_ready;
            con_data = proc_wdata;

            case (m_state)
                SEQ_IDLE:
                begin
                    check_val(1, "proc_data_ready", 32'(cache_ready), 32'(proc_data_ready));
                    check_val(1, "proc_rdata", cache_rdata, proc_rdata);
                    check_val(1, "fetch_hold", 0, 32'(fetch_hold));
                    if (wr_valid || rd_addr_valid)
                        flag_error(1, "peripheral channel active with no peripheral access");
                    if (is_peri && acc && cache_ready && fetch_ready)
                    begin
                        m_state  = SEQ_ISSUE;
                        m_write  = (proc_ctrl == `CTRL_WRITE);
                        m_addr   = proc_addr;
                        m_wdata  = proc_wdata;
                        m_strb   = proc_strb;
                        m_wr_hs  = 1'b0;
                        m_wr_cnt = 0;
                        m_rd_cnt = 0;
                    end
                end
                SEQ_ISSUE, SEQ_WAIT:
                begin
                    check_val(pidx, "fetch_hold", 1, 32'(fetch_hold));
                    check_val(pidx, "proc_data_ready", 0, 32'(proc_data_ready));
                    if (wr_valid && wr_ready)
                    begin
                        m_wr_cnt++;
                        m_wr_hs = 1'b1;
                        check_val(3, "wr_addr", m_addr, wr_addr);
                        check_val(3, "wr_data", m_wdata, wr_data);
                        check_val(3, "wr_strb", 32'(m_strb), 32'(wr_strb));
                    end
                    if (rd_addr_valid && rd_addr_ready)
                    begin
                        m_rd_cnt++;
                        check_val(4, "rd_addr", m_addr, rd_addr);
                    end
                    if (m_done)
                        m_state = SEQ_RESPOND;
                    else if (m_state == SEQ_ISSUE)
                        m_state = SEQ_WAIT;
                    else if (rd_data_valid && rd_data_ready)
                    begin
                        m_rdata = rd_data;
                        m_done  = 1'b1;
                    end
                    else if (trans_complete && m_wr_hs)
                        m_done = 1'b1;
                end
                SEQ_RESPOND:
                begin
                    check_val(pidx, "fetch_hold", 0, 32'(fetch_hold));
                    check_val(pidx, "proc_data_ready", 1, 32'(proc_data_ready));
                    check_val(pidx, "proc_rdata", m_write ? 0 : m_rdata, proc_rdata);
                    if (m_write && (m_wr_cnt != 1 || m_rd_cnt != 0))
                        flag_error(3, "peripheral write did not issue exactly one write");
                    if (!m_write && (m_rd_cnt != 1 || m_wr_cnt != 0))
                        flag_error(4, "peripheral read did not issue exactly one read address");
                    m_state = SEQ_IDLE;
                    m_done  = 1'b0;
                end
                default: m_state = SEQ_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: test/dbus_router_tb.sv
`timescale 1ns/10ps
`default_nettype none
`include "dbus_consts.svh"

module dbus_router_tb;
    import dbus_pkg::*;

    localparam int NUM_ACCESSES = 300;
    localparam int CLK_PERIOD   = 4;

    logic  CLK;
    logic  reset;
    ctrl_t proc_ctrl;
    addr_t proc_addr;
    data_t proc_wdata;
    strb_t proc_strb;
    logic  proc_data_ready;
    data_t proc_rdata;
    logic  fetch_hold;
    logic  cache_ready;
    logic  fetch_ready;
    data_t cache_rdata;
    ctrl_t cache_ctrl;
    logic  console_wr_en;
    data_t console_wr_data;
    addr_t rd_addr;
    logic  rd_addr_valid;
    logic  rd_addr_ready;
    addr_t wr_addr;
    logic  wr_valid;
    logic  wr_ready;
    data_t wr_data;
    strb_t wr_strb;
    data_t rd_data;
    logic  rd_data_valid;
    logic  rd_data_ready;
    logic  trans_complete;

    logic [31:0] lfsr = 32'd86;

    dbus_router dut_i (.*);

    dbus_router_checker chk_i (.*);

    initial
    begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    //////////////////////////////
    // Random source
    //////////////////////////////
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    // Caches ready about three cycles in four
    task automatic shuffle_cache();
        logic [31:0] r;
        rand_bits(4, r);
        cache_ready = r[0] | r[1];
        fetch_ready = r[2] | r[3];
        rand_bits(32, r);
        cache_rdata = r;
    endtask

    task automatic run_access();
        logic [31:0] r;
        logic [1:0]  region;
        logic        accepted;
        logic        finished;
        rand_bits(2, r);
        region = r[1:0];
        @(posedge CLK);
        #1;
        rand_bits(28, r);
        case (region)
            2'd0:
            begin
                proc_addr = {4'h0, r[27:0]};
                if (proc_addr == `CONSOLE_ADDR)
                    proc_addr = proc_addr ^ 32'h4;
            end
            2'd1:    proc_addr = `CONSOLE_ADDR;
            default: proc_addr = `PERIPH_BASE_ADDR + {4'h0, r[27:0]};
        endcase
        rand_bits(1, r);
        proc_ctrl = (region == 2'd1 || r[0]) ? `CTRL_WRITE : `CTRL_READ;
        rand_bits(32, r);
        proc_wdata = r;
        rand_bits(4, r);
        proc_strb = r[3:0];
        shuffle_cache();
        accepted = 1'b0;
        finished = 1'b0;
        while (!finished)
        begin
            @(negedge CLK);
            case (region)
                2'd0:    finished = proc_data_ready;
                2'd1:    finished = cache_ready && fetch_ready;
                default:
                    if (!accepted)
                        accepted = cache_ready && fetch_ready;
                    else
                        finished = proc_data_ready;
            endcase
            @(posedge CLK);
            #1;
            if (finished)
                proc_ctrl = `CTRL_NONE;
            shuffle_cache();
        end
    endtask

    //////////////////////////////
    // Peripheral slave model
    //////////////////////////////
    always @(posedge CLK)
    begin
        logic [31:0] r;
        int wr_cnt;
        int cmp_cnt;
        int ra_cnt;
        int rd_cnt;
        logic wr_busy;
        logic cmp_wait;
        logic ra_busy;
        logic rd_busy;
        #1;
        if (reset)
        begin
            wr_ready       = 1'b0;
            rd_addr_ready  = 1'b0;
            rd_data_valid  = 1'b0;
            trans_complete = 1'b0;
            wr_busy  = 1'b0;
            cmp_wait = 1'b0;
            ra_busy  = 1'b0;
            rd_busy  = 1'b0;
        end
        else
        begin
            trans_complete = 1'b0;
            if (wr_ready)
            begin
                wr_ready = 1'b0;
                cmp_wait = 1'b1;
                rand_bits(3, r);
                cmp_cnt = r;
            end
            else if (wr_valid)
            begin
                if (!wr_busy)
                begin
                    wr_busy = 1'b1;
                    rand_bits(3, r);
                    wr_cnt = r;
                end
                if (wr_cnt == 0)
                begin
                    wr_ready = 1'b1;
                    wr_busy  = 1'b0;
                end
                else
                    wr_cnt--;
            end
            if (cmp_wait)
            begin
                if (cmp_cnt == 0)
                begin
                    trans_complete = 1'b1;
                    cmp_wait       = 1'b0;
                end
                else
                    cmp_cnt--;
            end
            if (rd_addr_ready)
                rd_addr_ready = 1'b0;
            else if (rd_addr_valid)
            begin
                if (!ra_busy)
                begin
                    ra_busy = 1'b1;
                    rand_bits(3, r);
                    ra_cnt = r;
                end
                if (ra_cnt == 0)
                begin
                    rd_addr_ready = 1'b1;
                    ra_busy       = 1'b0;
                end
                else
                    ra_cnt--;
            end
            if (rd_data_valid)
                rd_data_valid = 1'b0;
            else if (rd_data_ready)
            begin
                if (!rd_busy)
                begin
                    rd_busy = 1'b1;
                    rand_bits(3, r);
                    rd_cnt = r;
                end
                if (rd_cnt == 0)
                begin
                    rand_bits(32, r);
                    rd_data       = r;
                    rd_data_valid = 1'b1;
                    rd_busy       = 1'b0;
                end
                else
                    rd_cnt--;
            end
        end
    end

    // Watchdog
    initial
    begin
        #((NUM_ACCESSES * 40 + 16) * CLK_PERIOD);
        $display("Watchdog expired: the accesses did not complete in time");
        $display("TEST FAILED");
        $finish;
    end

    initial
    begin
        reset          = 1'b1;
        proc_ctrl      = `CTRL_NONE;
        proc_addr      = '0;
        proc_wdata     = '0;
        proc_strb      = '0;
        cache_ready    = 1'b0;
        fetch_ready    = 1'b0;
        cache_rdata    = '0;
        rd_data        = '0;
        wr_ready       = 1'b0;
        rd_addr_ready  = 1'b0;
        rd_data_valid  = 1'b0;
        trans_complete = 1'b0;
        repeat (16) @(posedge CLK);
        #1;
        reset = 1'b0;
        for (int n = 0; n < NUM_ACCESSES; n++)
            run_access();
        repeat (4) @(posedge CLK);
        chk_i.report();
        if (chk_i.err_count == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: dbus_router.f
+incdir+source
source/dbus_pkg.sv
source/peri_pkg.sv
source/peri_req_if.sv
source/access_decoder.sv
source/peri_sequencer.sv
source/peri_bus_master.sv
source/dbus_router.sv
test/dbus_router_checker.sv
test/dbus_router_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := dbus_router_tb
FILELIST  := dbus_router.f
FLAGS     := --timing --assert
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
